// ==== design/balance_consts.svh ====
`ifndef BALANCE_CONSTS_SVH
`define BALANCE_CONSTS_SVH

// serial bit time in clk cycles
// start bit is checked at half of this, data and stop bits at full
`define CLKS_PER_BIT 16

// integral sum clamp, symmetric around zero
// keeps windup bounded while the robot is held over
`define INTEG_LIMIT 300

// saturation of the pid output, symmetric
// must stay below PWM_PERIOD so the duty fits one period
`define POWER_MAX 1023

// pwm counter period in clk cycles
`define PWM_PERIOD 1024

// cycles each display digit stays lit
`define SCAN_DIV 64

// cycles without an angle frame before the motors are cut
`define ANGLE_TIMEOUT 4096

`endif

// ==== design/balancePkg.sv ====
package balancePkg;

  // tilt angle from the mcu, tenths of a degree
  // upright is around 1800
  typedef logic [15:0] angleT;

  // motor power, two's complement
  // positive drives forward
  typedef logic signed [15:0] powerT;

  // direction code to the h-bridge
  // same encoding as the original board leds
  typedef enum logic [1:0] {
    dirStop    = 2'b00,
    dirForward = 2'b01,
    dirReverse = 2'b10
  } motorDirT;

  // sample sequencer states
  // one sample in flight at a time
  typedef enum logic [1:0] {
    stIdle = 2'b00,
    stStep = 2'b01,
    stWait = 2'b10,
    stLoad = 2'b11
  } ctrlStateT;

endpackage

// ==== design/angleRx.sv ====
`timescale 1ns/1ps
`include "balance_consts.svh"

module angleRx (
  input  logic              clk,
  input  logic              arstN,
  input  logic              rxSerial,
  output balancePkg::angleT angle,
  output logic              angleValid
);

  localparam int BitCntW = $clog2(`CLKS_PER_BIT);
  localparam logic [BitCntW-1:0] BitLast = BitCntW'(`CLKS_PER_BIT - 1);
  localparam logic [BitCntW-1:0] HalfLast = BitCntW'(`CLKS_PER_BIT / 2 - 1);

  // rxBreak waits for the line to return high after a bad stop bit
  typedef enum logic [2:0] {
    rxIdle,
    rxStart,
    rxData,
    rxStop,
    rxBreak
  } rxStateT;

  rxStateT            rxState;
  logic [1:0]         syncReg;
  logic               rxIn;
  logic [BitCntW-1:0] clkCnt;
  logic [2:0]         bitIdx;
  logic [7:0]         shiftReg;
  logic [7:0]         lowByte;
  // set once the low byte of a frame is held
  logic               highPending;
  logic               bitSample;
  logic               byteDone;

  assign rxIn = syncReg[1];
  // mid-bit point of a data bit
  assign bitSample = (rxState == rxData) && (clkCnt == BitLast);
  // stop bit seen high at mid-bit
  assign byteDone = (rxState == rxStop) && (clkCnt == BitLast) && rxIn;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      // idle line is high
      syncReg     <= 2'b11;
      rxState     <= rxIdle;
      clkCnt      <= '0;
      bitIdx      <= '0;
      highPending <= 1'b0;
      angleValid  <= 1'b0;
    end else begin
      syncReg    <= {syncReg[0], rxSerial};
      angleValid <= 1'b0;
      case (rxState)
        rxIdle: begin
          clkCnt <= '0;
          if (!rxIn) begin
            rxState <= rxStart;
          end
        end
        rxStart: begin
          if (clkCnt == HalfLast) begin
            clkCnt <= '0;
            bitIdx <= '0;
            // line back high at mid start bit, just a glitch
            rxState <= rxIn ? rxIdle : rxData;
          end else begin
            clkCnt <= clkCnt + 1'b1;
          end
        end
        rxData: begin
          if (clkCnt == BitLast) begin
            clkCnt <= '0;
            bitIdx <= bitIdx + 1'b1;
            if (bitIdx == 3'd7) begin
              rxState <= rxStop;
            end
          end else begin
            clkCnt <= clkCnt + 1'b1;
          end
        end
        rxStop: begin
          if (clkCnt == BitLast) begin
            clkCnt <= '0;
            if (rxIn) begin
              rxState     <= rxIdle;
              highPending <= !highPending;
              // second byte closes the frame
              angleValid  <= highPending;
            end else begin
              // framing error, restart pairing at the low byte
              rxState     <= rxBreak;
              highPending <= 1'b0;
            end
          end else begin
            clkCnt <= clkCnt + 1'b1;
          end
        end
        rxBreak: begin
          if (rxIn) begin
            rxState <= rxIdle;
          end
        end
        default: rxState <= rxIdle;
      endcase
    end
  end

  // byte payload, lsb first on the wire
  always_ff @(posedge clk) begin
    if (bitSample) begin
      shiftReg <= {rxIn, shiftReg[7:1]};
    end
    if (byteDone && !highPending) begin
      lowByte <= shiftReg;
    end
    if (byteDone && highPending) begin
      angle <= {shiftReg, lowByte};
    end
  end

endmodule

// ==== design/pidCore.sv ====
`timescale 1ns/1ps
`include "balance_consts.svh"

module pidCore #(
  parameter int KP = 4,
  parameter int KI = 1,
  parameter int KD = 2
) (
  input  logic              clk,
  input  logic              arstN,
  input  logic              pidStep,
  input  balancePkg::angleT angle,
  input  balancePkg::angleT targetAngle,
  output logic              pidDone,
  output balancePkg::powerT pidPower
);

  import balancePkg::*;

  localparam int IntegLimit = `INTEG_LIMIT;
  localparam int PowerMax = `POWER_MAX;

  // stage 1 terms, wide enough for the full angle range
  logic signed [17:0] error;
  logic signed [17:0] integSum;
  logic signed [17:0] integNext;
  logic signed [18:0] deriv;
  // errReg doubles as the previous error for the next sample
  logic signed [17:0] errReg;
  logic signed [17:0] integReg;
  logic signed [18:0] derivReg;
  logic               stage1Valid;
  // stage 2
  logic signed [31:0] weighted;
  powerT              satPower;

  always_comb begin
    // angles are unsigned, error is signed
    error    = $signed({2'b00, angle}) - $signed({2'b00, targetAngle});
    integSum = integReg + error;
    // clamp the running sum
    if (integSum > IntegLimit) begin
      integNext = 18'(IntegLimit);
    end else if (integSum < -IntegLimit) begin
      integNext = 18'(-IntegLimit);
    end else begin
      integNext = integSum;
    end
    // per-sample difference, no time scaling
    deriv = error - errReg;
  end

  always_comb begin
    weighted = KP * errReg + KI * integReg + KD * derivReg;
    // saturate to the motor range
    if (weighted > PowerMax) begin
      satPower = powerT'(PowerMax);
    end else if (weighted < -PowerMax) begin
      satPower = powerT'(-PowerMax);
    end else begin
      satPower = weighted[15:0];
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      errReg      <= '0;
      integReg    <= '0;
      derivReg    <= '0;
      stage1Valid <= 1'b0;
      pidDone     <= 1'b0;
      pidPower    <= '0;
    end else begin
      stage1Valid <= pidStep;
      pidDone     <= stage1Valid;
      // stage 1 at pidStep
      if (pidStep) begin
        errReg   <= error;
        integReg <= integNext;
        derivReg <= deriv;
      end
      // stage 2, result held until the next sample
      if (stage1Valid) begin
        pidPower <= satPower;
      end
    end
  end

endmodule

// ==== design/motorPwm.sv ====
`timescale 1ns/1ps
`include "balance_consts.svh"

module motorPwm (
  input  logic                 clk,
  input  logic                 arstN,
  input  logic                 loadPower,
  input  logic                 motorEnable,
  input  balancePkg::powerT    pidPower,
  output balancePkg::powerT    power,
  output balancePkg::motorDirT leftDir,
  output balancePkg::motorDirT rightDir,
  output logic                 leftPwm,
  output logic                 rightPwm
);

  import balancePkg::*;

  localparam int CntW = $clog2(`PWM_PERIOD);
  localparam logic [CntW-1:0] CntLast = CntW'(`PWM_PERIOD - 1);

  logic [CntW-1:0] pwmCnt;
  logic [15:0]     magnitude;
  // duty in force for the running period
  logic [15:0]     dutyActive;
  motorDirT        dir;
  logic            pwmOut;

  // sign/magnitude split of the latched power
  assign magnitude = power[15] ? 16'(-power) : 16'(power);

  always_comb begin
    if (!motorEnable || power == 0) begin
      dir = dirStop;
    end else if (power > 0) begin
      dir = dirForward;
    end else begin
      dir = dirReverse;
    end
  end

  assign pwmOut = motorEnable && (16'(pwmCnt) < dutyActive);

  // no steering, both wheels get the same drive
  assign leftDir  = dir;
  assign rightDir = dir;
  assign leftPwm  = pwmOut;
  assign rightPwm = pwmOut;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      power      <= '0;
      pwmCnt     <= '0;
      dutyActive <= '0;
    end else begin
      if (loadPower) begin
        power <= pidPower;
      end
      pwmCnt <= (pwmCnt == CntLast) ? '0 : pwmCnt + 1'b1;
      // new duty only at a period boundary
      if (pwmCnt == CntLast) begin
        dutyActive <= magnitude;
      end
    end
  end

endmodule

// ==== design/segDisplay.sv ====
`timescale 1ns/1ps
`include "balance_consts.svh"

module segDisplay (
  input  logic              clk,
  input  logic              arstN,
  input  logic              loadPower,
  input  balancePkg::powerT pidPower,
  output logic [6:0]        seg,
  output logic [3:0]        an,
  output logic              dp
);

  localparam int DivW = $clog2(`SCAN_DIV);
  localparam logic [DivW-1:0] DivLast = DivW'(`SCAN_DIV - 1);

  logic [15:0]     magReg;
  logic            posReg;
  logic [DivW-1:0] divCnt;
  logic [1:0]      digitIdx;
  logic [3:0]      nibble;

  // active-low segments, bit order gfedcba
  function automatic logic [6:0] hexToSeg(input logic [3:0] value);
    case (value)
      4'h0: hexToSeg = 7'b1000000;
      4'h1: hexToSeg = 7'b1111001;
      4'h2: hexToSeg = 7'b0100100;
      4'h3: hexToSeg = 7'b0110000;
      4'h4: hexToSeg = 7'b0011001;
      4'h5: hexToSeg = 7'b0010010;
      4'h6: hexToSeg = 7'b0000010;
      4'h7: hexToSeg = 7'b1111000;
      4'h8: hexToSeg = 7'b0000000;
      4'h9: hexToSeg = 7'b0010000;
      4'ha: hexToSeg = 7'b0001000;
      4'hb: hexToSeg = 7'b0000011;
      4'hc: hexToSeg = 7'b1000110;
      4'hd: hexToSeg = 7'b0100001;
      4'he: hexToSeg = 7'b0000110;
      default: hexToSeg = 7'b0001110;
    endcase
  endfunction

  // digit 0 is the least significant nibble
  assign nibble = magReg[digitIdx*4 +: 4];
  assign an     = ~(4'b0001 << digitIdx);
  assign seg    = hexToSeg(nibble);
  // decimal point marks positive power
  assign dp     = posReg;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      magReg   <= '0;
      posReg   <= 1'b0;
      divCnt   <= '0;
      digitIdx <= '0;
    end else begin
      if (loadPower) begin
        magReg <= pidPower[15] ? -pidPower : pidPower;
        posReg <= (pidPower > 0);
      end
      // scan divider, next digit on wrap
      divCnt <= (divCnt == DivLast) ? '0 : divCnt + 1'b1;
      if (divCnt == DivLast) begin
        digitIdx <= digitIdx + 1'b1;
      end
    end
  end

endmodule

// ==== design/balanceCtrl.sv ====
`timescale 1ns/1ps
`include "balance_consts.svh"

module balanceCtrl (
  input  logic clk,
  input  logic arstN,
  input  logic angleValid,
  input  logic pidDone,
  output logic pidStep,
  output logic loadPower,
  output logic motorEnable,
  output logic fault
);

  import balancePkg::*;

  localparam int WdW = $clog2(`ANGLE_TIMEOUT + 1);
  localparam logic [WdW-1:0] WdLimit = WdW'(`ANGLE_TIMEOUT);

  ctrlStateT      state;
  logic [WdW-1:0] staleCnt;
  logic           stale;

  // strobes are decoded from the state, one cycle each
  assign pidStep   = (state == stStep);
  assign loadPower = (state == stLoad);
  assign stale     = (staleCnt == WdLimit);

  // one sample per frame, frames during a sample are dropped
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= stIdle;
    end else begin
      case (state)
        stIdle: begin
          if (angleValid) begin
            state <= stStep;
          end
        end
        stStep: state <= stWait;
        stWait: begin
          if (pidDone) begin
            state <= stLoad;
          end
        end
        default: state <= stIdle;
      endcase
    end
  end

  // stale-angle watchdog, saturates at the limit
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      staleCnt    <= '0;
      fault       <= 1'b0;
      motorEnable <= 1'b0;
    end else begin
      if (angleValid) begin
        staleCnt <= '0;
      end else if (!stale) begin
        staleCnt <= staleCnt + 1'b1;
      end
      // a fresh power value clears the fault
      if (loadPower) begin
        fault       <= 1'b0;
        motorEnable <= 1'b1;
      end else if (stale) begin
        fault       <= 1'b1;
        motorEnable <= 1'b0;
      end
    end
  end

endmodule

// ==== design/balanceTop.sv ====
`timescale 1ns/1ps

module balanceTop (
  input  logic                 clk,
  input  logic                 arstN,
  input  logic                 rxSerial,
  input  balancePkg::angleT    targetAngle,
  output balancePkg::powerT    power,
  output logic                 powerValid,
  output logic                 fault,
  output balancePkg::motorDirT leftDir,
  output balancePkg::motorDirT rightDir,
  output logic                 leftPwm,
  output logic                 rightPwm,
  output logic [6:0]           seg,
  output logic [3:0]           an,
  output logic                 dp
);

  import balancePkg::*;

  angleT angle;
  logic  angleValid;
  logic  pidStep;
  logic  pidDone;
  logic  loadPower;
  logic  motorEnable;
  powerT pidPower;

  // telemetry strobe, same cycle the drive latches
  assign powerValid = loadPower;

  // tilt frames from the mcu
  angleRx rx (
    .clk       (clk),
    .arstN     (arstN),
    .rxSerial  (rxSerial),
    .angle     (angle),
    .angleValid(angleValid)
  );

  // sequencing and watchdog
  balanceCtrl ctrl (
    .clk        (clk),
    .arstN      (arstN),
    .angleValid (angleValid),
    .pidDone    (pidDone),
    .pidStep    (pidStep),
    .loadPower  (loadPower),
    .motorEnable(motorEnable),
    .fault      (fault)
  );

  pidCore pid (
    .clk        (clk),
    .arstN      (arstN),
    .pidStep    (pidStep),
    .angle      (angle),
    .targetAngle(targetAngle),
    .pidDone    (pidDone),
    .pidPower   (pidPower)
  );

  // power output is the copy held by the motor driver
  motorPwm motor (
    .clk        (clk),
    .arstN      (arstN),
    .loadPower  (loadPower),
    .motorEnable(motorEnable),
    .pidPower   (pidPower),
    .power      (power),
    .leftDir    (leftDir),
    .rightDir   (rightDir),
    .leftPwm    (leftPwm),
    .rightPwm   (rightPwm)
  );

  segDisplay display (
    .clk      (clk),
    .arstN    (arstN),
    .loadPower(loadPower),
    .pidPower (pidPower),
    .seg      (seg),
    .an       (an),
    .dp       (dp)
  );

endmodule

// ==== tests/balanceTb.sv ====
`timescale 1ns/1ps
`include "balance_consts.svh"

module balanceTb;

  import balancePkg::*;

  // same gains as the pidCore defaults
  localparam int Kp = 4;
  localparam int Ki = 1;
  localparam int Kd = 2;
  localparam int Target = 1800;
  localparam int FrameCount = 25;
  // serial time of all frames, one fault wait, a few pwm periods, plus half again
  localparam int TimeoutCycles =
    (FrameCount * 2 * 10 * `CLKS_PER_BIT + `ANGLE_TIMEOUT + 4 * `PWM_PERIOD) * 3 / 2;

  logic       clk = 1'b0;
  logic       arstN;
  logic       rxSerial;
  angleT      targetAngle;
  powerT      power;
  logic       powerValid;
  logic       fault;
  motorDirT   leftDir;
  motorDirT   rightDir;
  logic       leftPwm;
  logic       rightPwm;
  logic [6:0] seg;
  logic [3:0] an;
  logic       dp;

  int    seed = 71972;
  int    errorCount = 0;
  int    framesSent = 0;
  int    framesExpected = 0;
  int    pulsesSeen = 0;
  // cycles since the last powerValid
  int    sinceValid = 0;
  int    modelInteg = 0;
  int    modelPrevErr = 0;
  powerT expTable [0:63];
  powerT expPower = '0;
  logic  powerArmed = 1'b0;
  // phase mirrors the free-running pwm counter
  int    pwmPhase = 0;
  int    highCount = 0;
  int    periodDuty = 0;
  logic  periodUsable = 1'b0;
  logic  faultInPeriod = 1'b0;
  int    doneHigh = 0;
  int    doneDuty = 0;
  logic  doneCheck = 1'b0;

  angleT directedAngles [0:11] = '{
    16'd1800, 16'd2000, 16'd2000, 16'd2000, 16'd1600, 16'd1600,
    16'd1500, 16'd1400, 16'd1300, 16'd0, 16'd65535, 16'd1800
  };

  balanceTop uut (
    .clk        (clk),
    .arstN      (arstN),
    .rxSerial   (rxSerial),
    .targetAngle(targetAngle),
    .power      (power),
    .powerValid (powerValid),
    .fault      (fault),
    .leftDir    (leftDir),
    .rightDir   (rightDir),
    .leftPwm    (leftPwm),
    .rightPwm   (rightPwm),
    .seg        (seg),
    .an         (an),
    .dp         (dp)
  );

  always #20 clk = ~clk;

  function automatic int magnitudeOf(input powerT value);
    return (value < 0) ? -int'(value) : int'(value);
  endfunction

  // sign of power picks the direction
  // stop when the drive is off
  function automatic motorDirT dirFor(input powerT value, input logic enabled);
    if (!enabled || value == 0) begin
      return dirStop;
    end
    return (value > 0) ? dirForward : dirReverse;
  endfunction

  // common-anode digit with segments gfedcba
  // a low segment is lit
  function automatic logic [6:0] segPattern(input logic [3:0] digit);
    case (digit)
      4'h0: return 7'h40;
      4'h1: return 7'h79;
      4'h2: return 7'h24;
      4'h3: return 7'h30;
      4'h4: return 7'h19;
      4'h5: return 7'h12;
      4'h6: return 7'h02;
      4'h7: return 7'h78;
      4'h8: return 7'h00;
      4'h9: return 7'h10;
      4'ha: return 7'h08;
      4'hb: return 7'h03;
      4'hc: return 7'h46;
      4'hd: return 7'h21;
      4'he: return 7'h06;
      default: return 7'h0e;
    endcase
  endfunction

  function automatic logic [6:0] segFor(input logic [3:0] anode, input powerT value);
    int digit;
    digit = 0;
    for (int i = 0; i < 4; i++) begin
      if (!anode[i]) begin
        digit = i;
      end
    end
    return segPattern(4'((magnitudeOf(value) >> (4 * digit)) & 15));
  endfunction

  // reference pid with clamped integral, per-sample derivative and saturated sum
  task automatic predict(input angleT angleVal, output powerT result);
    int err;
    int sum;
    err = int'(angleVal) - Target;
    modelInteg = modelInteg + err;
    if (modelInteg > `INTEG_LIMIT) begin
      modelInteg = `INTEG_LIMIT;
    end else if (modelInteg < -`INTEG_LIMIT) begin
      modelInteg = -`INTEG_LIMIT;
    end
    sum = Kp * err + Ki * modelInteg + Kd * (err - modelPrevErr);
    modelPrevErr = err;
    if (sum > `POWER_MAX) begin
      sum = `POWER_MAX;
    end else if (sum < -`POWER_MAX) begin
      sum = -`POWER_MAX;
    end
    result = powerT'(sum);
  endtask

  task automatic driveBit(input logic value);
    rxSerial <= value;
    repeat (`CLKS_PER_BIT) @(posedge clk);
  endtask

  // 8N1 byte sent lsb first
  // a counted byte closes a frame at its stop bit
  task automatic sendByte(input logic [7:0] data, input logic stopBit, input logic countFrame);
    driveBit(1'b0);
    for (int i = 0; i < 8; i++) begin
      driveBit(data[i]);
    end
    if (countFrame) begin
      framesExpected <= framesExpected + 1;
    end
    driveBit(stopBit);
  endtask

  task automatic sendFrame(input angleT angleVal);
    powerT predicted;
    framesSent <= framesSent + 1;
    predict(angleVal, predicted);
    expTable[framesExpected % 64] = predicted;
    sendByte(angleVal[7:0], 1'b1, 1'b0);
    sendByte(angleVal[15:8], 1'b1, 1'b1);
    // wait for the pulse of this frame
    while (pulsesSeen < framesExpected) begin
      @(posedge clk);
    end
    repeat (2 * `CLKS_PER_BIT) @(posedge clk);
  endtask

  // high byte ends in a low stop bit before the line goes idle
  task automatic sendBadFrame(input angleT angleVal);
    framesSent <= framesSent + 1;
    sendByte(angleVal[7:0], 1'b1, 1'b0);
    sendByte(angleVal[15:8], 1'b0, 1'b0);
    rxSerial <= 1'b1;
    repeat (4 * `CLKS_PER_BIT) @(posedge clk);
  endtask

  always @(posedge clk) begin
    if (!arstN) begin
      pwmPhase <= 0;
    end else begin
      pwmPhase <= (pwmPhase == `PWM_PERIOD - 1) ? 0 : pwmPhase + 1;
    end
    powerArmed <= powerValid;
    if (powerValid) begin
      expPower   <= expTable[pulsesSeen % 64];
      pulsesSeen <= pulsesSeen + 1;
      sinceValid <= 0;
    end else if (sinceValid < 2 * `ANGLE_TIMEOUT) begin
      sinceValid <= sinceValid + 1;
    end
    // at the last cycle of a period hand the count over and take the next duty
    if (pwmPhase == `PWM_PERIOD - 1) begin
      doneHigh      <= highCount + int'(leftPwm);
      doneDuty      <= periodDuty;
      doneCheck     <= periodUsable && !faultInPeriod && !fault;
      highCount     <= 0;
      periodDuty    <= magnitudeOf(expPower);
      periodUsable  <= (pulsesSeen > 0);
      faultInPeriod <= 1'b0;
    end else begin
      highCount     <= highCount + int'(leftPwm);
      faultInPeriod <= faultInPeriod || fault;
      doneCheck     <= 1'b0;
    end
  end

  resetState: assert property (@(posedge clk) disable iff (!arstN)
    framesSent != 0 ||
    {powerValid, fault, leftPwm, rightPwm, leftDir, rightDir, power, dp} == '0)
  else begin
    errorCount++;
    $display("** Error reset state: expected %h, actual %h", 25'h0,
      $sampled({powerValid, fault, leftPwm, rightPwm, leftDir, rightDir, power, dp}));
  end

  powerValue: assert property (@(posedge clk) disable iff (!arstN)
    !powerArmed || power == expPower)
  else begin
    errorCount++;
    $display("** Error power frame %0d: expected %0d, actual %0d",
      $sampled(pulsesSeen), $sampled(expPower), $sampled(power));
  end

  extraPulse: assert property (@(posedge clk) disable iff (!arstN)
    !powerValid || pulsesSeen < framesExpected)
  else begin
    errorCount++;
    $display("powerValid pulsed with no valid frame pending");
  end

  faultCleared: assert property (@(posedge clk) disable iff (!arstN)
    !powerArmed || !fault)
  else begin
    errorCount++;
    $display("** Error fault after powerValid: expected 0, actual %b", $sampled(fault));
  end

  direction: assert property (@(posedge clk) disable iff (!arstN)
    leftDir == dirFor(expPower, pulsesSeen > 0 && !fault) && rightDir == leftDir)
  else begin
    errorCount++;
    $display("** Error direction: expected %0d, actual %0d and %0d",
      dirFor($sampled(expPower), $sampled(pulsesSeen) > 0 && !$sampled(fault)),
      $sampled(leftDir), $sampled(rightDir));
  end

  pwmPair: assert property (@(posedge clk) disable iff (!arstN) rightPwm == leftPwm)
  else begin
    errorCount++;
    $display("** Error pwm pair: expected %b, actual %b", $sampled(leftPwm), $sampled(rightPwm));
  end

  pwmDuty: assert property (@(posedge clk) disable iff (!arstN)
    !doneCheck || doneHigh == doneDuty)
  else begin
    errorCount++;
    $display("** Error pwm duty: expected %0d, actual %0d", $sampled(doneDuty), $sampled(doneHigh));
  end

  faultDrive: assert property (@(posedge clk) disable iff (!arstN)
    !fault || (!leftPwm && !rightPwm))
  else begin
    errorCount++;
    $display("** Error pwm during fault: expected 00, actual %b%b",
      $sampled(leftPwm), $sampled(rightPwm));
  end

  faultEarly: assert property (@(posedge clk) disable iff (!arstN)
    !(fault && sinceValid < `ANGLE_TIMEOUT - 8))
  else begin
    errorCount++;
    $display("fault raised after only %0d cycles without an angle", $sampled(sinceValid));
  end

  faultLate: assert property (@(posedge clk) disable iff (!arstN)
    !(!fault && sinceValid > `ANGLE_TIMEOUT + 8))
  else begin
    errorCount++;
    $display("fault still low after %0d cycles without an angle", $sampled(sinceValid));
  end

  displayDigit: assert property (@(posedge clk) disable iff (!arstN)
    $countones(~an) == 1 && seg == segFor(an, expPower))
  else begin
    errorCount++;
    $display("** Error display digit an %b: expected %h, actual %h", $sampled(an),
      segFor($sampled(an), $sampled(expPower)), $sampled(seg));
  end

  decimalPoint: assert property (@(posedge clk) disable iff (!arstN) dp == (expPower > 0))
  else begin
    errorCount++;
    $display("** Error decimal point: expected %b, actual %b",
      $sampled(expPower) > 0, $sampled(dp));
  end

  initial begin
    int offset;
    arstN       = 1'b0;
    rxSerial    = 1'b1;
    targetAngle = angleT'(Target);
    repeat (3) @(posedge clk);
    arstN <= 1'b1;
    repeat (4) @(posedge clk);
    // zero power first, then both integral clamps and both output limits
    foreach (directedAngles[i]) begin
      sendFrame(directedAngles[i]);
    end
    for (int i = 0; i < 10; i++) begin
      offset = $random(seed) % 300;
      sendFrame(angleT'(Target + offset));
    end
    // framing error followed by a clean frame
    sendBadFrame(16'd2100);
    sendFrame(16'd1750);
    // frames stop until the watchdog trips
    while (fault !== 1'b1) begin
      @(posedge clk);
    end
    repeat (2 * `CLKS_PER_BIT) @(posedge clk);
    sendFrame(16'd1900);
    // full pwm periods with the drive restored
    repeat (3 * `PWM_PERIOD) @(posedge clk);
    $display("frames %0d, power updates %0d, errors %0d", framesSent, pulsesSeen, errorCount);
    if (errorCount == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    repeat (TimeoutCycles) @(posedge clk);
    $display("run did not finish within %0d cycles, errors %0d", TimeoutCycles, errorCount);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+design
design/balancePkg.sv
design/angleRx.sv
design/pidCore.sv
design/motorPwm.sv
design/segDisplay.sv
design/balanceCtrl.sv
design/balanceTop.sv
tests/balanceTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the balance testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

simOut=$(verilator --binary --timing --assert -Wno-fatal -f files.f \
  --top-module balanceTb 2>&1 && ./obj_dir/VbalanceTb 2>&1)
echo "$simOut"

echo "$simOut" | grep -qx "TEST PASSED" && exit 0 || exit 1
